/* Makefile */
SIM      = verilator
TOP      = tb_mem_stage
FILELIST = filelist.f
FLAGS    = --binary --timing --assert -j 0
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

/* data_ram.sv */
`timescale 1ns/10ps
`include "lsu_defines.svh"

module data_ram (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ram_req_i,
    input  logic                     ram_wen_i,
    input  logic [`LSU_ADDR_W-1:0]   ram_addr_i,    // byte address
    input  logic [`LSU_BYTES-1:0]    ram_wmask_i,
    input  logic [`LSU_DATA_W-1:0]   ram_wdata_i,
    output logic                     ram_ack_o,
    output logic [`LSU_DATA_W-1:0]   ram_rdata_o
);
    logic [`LSU_DATA_W-1:0]   mem [`RAM_WORDS];
    logic [`RAM_WORDS_W-1:0]  waddr;
    logic [3:0]               lat_cnt;             // cycles with req seen

    assign waddr = ram_addr_i[`RAM_WORDS_W+`DC_OFF_W-1:`DC_OFF_W];   // word bits

    initial begin
        for (int i = 0; i < `RAM_WORDS; i++) mem[i] = '0;   // zero filled at start
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ram_ack_o <= 1'b0;
            lat_cnt   <= '0;
        end else if (!ram_req_i) begin
            ram_ack_o <= 1'b0;                     // return to zero
            lat_cnt   <= '0;
        end else if (!ram_ack_o) begin
            if (lat_cnt == 4'(`RAM_LAT - 1)) ram_ack_o <= 1'b1;
            else lat_cnt <= lat_cnt + 4'd1;
        end
    end

    // access happens on the edge that raises ack
    always_ff @(posedge clk) begin
        if (!rst && ram_req_i && !ram_ack_o && lat_cnt == 4'(`RAM_LAT - 1)) begin
            if (ram_wen_i) begin
                for (int b = 0; b < `LSU_BYTES; b++) begin
                    if (ram_wmask_i[b]) mem[waddr][b*8 +: 8] <= ram_wdata_i[b*8 +: 8];
                end
            end
            ram_rdata_o <= mem[waddr];
        end
    end

endmodule

/* dcache.sv */
`timescale 1ns/10ps
`include "lsu_defines.svh"

module dcache (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     dc_valid_i,
    input  logic                     dc_wen_i,
    input  lsu_pkg::dcache_addr_u    dc_addr_i,
    input  logic [`LSU_BYTES-1:0]    dc_wmask_i,
    input  logic [`LSU_DATA_W-1:0]   dc_wdata_i,   // already lane shifted
    output logic                     dc_ready_o,   // one-cycle pulse
    output logic [`LSU_DATA_W-1:0]   dc_rdata_o,
    output logic                     ram_req_o,
    output logic                     ram_wen_o,
    output logic [`LSU_ADDR_W-1:0]   ram_addr_o,
    output logic [`LSU_BYTES-1:0]    ram_wmask_o,
    output logic [`LSU_DATA_W-1:0]   ram_wdata_o,
    input  logic                     ram_ack_i,
    input  logic [`LSU_DATA_W-1:0]   ram_rdata_i
);
    typedef enum logic [1:0] {C_IDLE, C_FILL, C_WRITE} cstate_e;

    cstate_e                  state_q;
    logic [`DC_LINES-1:0]     valid_q;                 // one bit per line
    logic [`DC_TAG_W-1:0]     tag_q  [`DC_LINES];
    logic [`LSU_DATA_W-1:0]   data_q [`DC_LINES];
    logic [`DC_INDEX_W-1:0]   idx;
    logic                     hit;
    logic                     accept;
    logic                     fill_done;
    logic                     wr_hit;

    assign idx       = dc_addr_i.f.index;
    assign hit       = valid_q[idx] && (tag_q[idx] == dc_addr_i.f.tag);
    // skip the cycle of our own ready pulse and wait out a trailing ram ack
    assign accept    = (state_q == C_IDLE) && dc_valid_i && !dc_ready_o && !ram_ack_i;
    assign fill_done = (state_q == C_FILL) && ram_ack_i;
    assign wr_hit    = accept && dc_wen_i && hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= C_IDLE;
            valid_q    <= '0;                          // all lines invalid in one cycle
            dc_ready_o <= 1'b0;
            ram_req_o  <= 1'b0;
        end else begin
            dc_ready_o <= 1'b0;
            case (state_q)
                C_IDLE: if (accept) begin
                    if (dc_wen_i || !hit) begin        // write-through or read miss
                        ram_req_o <= 1'b1;
                        state_q   <= dc_wen_i ? C_WRITE : C_FILL;
                    end else begin
                        dc_ready_o <= 1'b1;            // read hit, one cycle
                    end
                end
                C_FILL: if (ram_ack_i) begin
                    ram_req_o      <= 1'b0;
                    valid_q[idx]   <= 1'b1;
                    dc_ready_o     <= 1'b1;
                    state_q        <= C_IDLE;
                end
                default: if (ram_ack_i) begin          // write done in ram
                    ram_req_o  <= 1'b0;
                    dc_ready_o <= 1'b1;
                    state_q    <= C_IDLE;
                end
            endcase
        end
    end

    // line storage, ram request payload and read data
    always_ff @(posedge clk) begin
        if (accept) begin
            ram_wen_o   <= dc_wen_i;
            ram_addr_o  <= dc_addr_i.raw;
            ram_wmask_o <= dc_wmask_i;
            ram_wdata_o <= dc_wdata_i;
            dc_rdata_o  <= data_q[idx];                // used only on a read hit
        end
        if (wr_hit) begin
            for (int b = 0; b < `LSU_BYTES; b++) begin
                if (dc_wmask_i[b]) data_q[idx][b*8 +: 8] <= dc_wdata_i[b*8 +: 8];
            end
        end
        if (fill_done) begin
            tag_q[idx]  <= dc_addr_i.f.tag;
            data_q[idx] <= ram_rdata_i;
            dc_rdata_o  <= ram_rdata_i;
        end
    end

    a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        dc_ready_o |=> !dc_ready_o);

    // four-phase with the ram, ack must be back to zero first
    a_req_after_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(ram_req_o) |-> !$past(ram_ack_i));

endmodule

/* filelist.f */
+incdir+.
lsu_pkg.sv
data_ram.sv
load_align.sv
mem_access_ctrl.sv
dcache.sv
mem_stage_top.sv
tb_mem_stage.sv

/* load_align.sv */
`timescale 1ns/10ps
`include "lsu_defines.svh"

module load_align (
    input  logic [`LSU_DATA_W-1:0]   word_i,    // whole word from the cache
    input  logic [`DC_OFF_W-1:0]     off_i,     // byte offset of the load
    input  lsu_pkg::lsu_size_e       size_i,
    output logic [`LSU_DATA_W-1:0]   data_o
);
    import lsu_pkg::*;

    logic [`LSU_DATA_W-1:0] sh;

    assign sh = word_i >> {off_i, 3'b000};      // addressed byte to bit 0

    always_comb begin
        case (size_i)
            LSU_B:   data_o = {{(`LSU_DATA_W-8){sh[7]}}, sh[7:0]};      // lb
            LSU_H:   data_o = {{(`LSU_DATA_W-16){sh[15]}}, sh[15:0]};   // lh
            LSU_W:   data_o = {{(`LSU_DATA_W-32){sh[31]}}, sh[31:0]};   // lw
            LSU_BU:  data_o = {{(`LSU_DATA_W-8){1'b0}}, sh[7:0]};       // lbu
            LSU_HU:  data_o = {{(`LSU_DATA_W-16){1'b0}}, sh[15:0]};     // lhu
            LSU_WU:  data_o = {{(`LSU_DATA_W-32){1'b0}}, sh[31:0]};     // lwu
            default: data_o = sh;                     // ld, offset is zero
        endcase
    end

endmodule

/* lsu_defines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data path widths
`define LSU_ADDR_W   32    // byte address
`define LSU_DATA_W   64    // one doubleword
`define LSU_BYTES    8     // bytes per word, also mask width

// direct-mapped cache geometry, one word per line
`define DC_OFF_W     3     // byte offset inside a word
`define DC_INDEX_W   3     // eight lines
`define DC_LINES     8
`define DC_TAG_W     26    // addr bits above index and offset

// backing memory
`define RAM_WORDS_W  8     // 256 words
`define RAM_WORDS    256
`define RAM_LAT      2     // req to ack, in cycles

`endif

/* lsu_pkg.sv */
`include "lsu_defines.svh"

package lsu_pkg;

    // func3 of loads and stores, low two bits give log2 of the size
    typedef enum logic [2:0] {
        LSU_B  = 3'd0,   // byte, sign extend
        LSU_H  = 3'd1,   // half
        LSU_W  = 3'd2,   // word
        LSU_D  = 3'd3,   // doubleword
        LSU_BU = 3'd4,   // byte, zero extend
        LSU_HU = 3'd5,
        LSU_WU = 3'd6    // 3'd7 is illegal
    } lsu_size_e;

    // cache view of a byte address
    typedef struct packed {
        logic [`DC_TAG_W-1:0]   tag;
        logic [`DC_INDEX_W-1:0] index;
        logic [`DC_OFF_W-1:0]   offset;   // ignored by the cache, word lines
    } dcache_fields_t;

    typedef union packed {
        logic [`LSU_ADDR_W-1:0] raw;      // written by the controller
        dcache_fields_t         f;        // decoded by the cache
    } dcache_addr_u;

endpackage

/* mem_access_ctrl.sv */
`timescale 1ns/10ps
`include "lsu_defines.svh"

module mem_access_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_i,        // execute request, held until ack
    input  logic                     wen_i,        // 1 store, 0 load
    input  lsu_pkg::lsu_size_e       func3_i,
    input  logic [`LSU_ADDR_W-1:0]   addr_i,
    input  logic [`LSU_DATA_W-1:0]   wdata_i,
    output logic                     ack_o,
    output logic                     err_o,
    output logic [`LSU_DATA_W-1:0]   rdata_o,
    output logic                     dc_valid_o,
    output logic                     dc_wen_o,
    output lsu_pkg::dcache_addr_u    dc_addr_o,
    output logic [`LSU_BYTES-1:0]    dc_wmask_o,
    output logic [`LSU_DATA_W-1:0]   dc_wdata_o,
    input  logic                     dc_ready_i,
    input  logic [`LSU_DATA_W-1:0]   dc_rdata_i,
    output logic [`LSU_DATA_W-1:0]   ld_word_o,    // to load_align
    output logic [`DC_OFF_W-1:0]     ld_off_o,
    output lsu_pkg::lsu_size_e       ld_size_o,
    input  logic [`LSU_DATA_W-1:0]   ld_data_i     // aligned and extended load
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_BUSY, S_DONE} state_e;

    state_e                  state_q;
    lsu_size_e               size_q;       // func3 of the access in flight
    logic [1:0]              sz_log;
    logic [`DC_OFF_W-1:0]    off;
    logic [3:0]              low_mask;
    logic                    misalign;
    logic                    bad_op;
    logic [`LSU_BYTES-1:0]   base_mask;

    assign sz_log   = func3_i[1:0];
    assign off      = addr_i[`DC_OFF_W-1:0];
    assign low_mask = (4'd1 << sz_log) - 4'd1;          // 0,1,3,7 for b/h/w/d
    assign misalign = |(off & low_mask[2:0]);           // offset not a multiple of size
    assign bad_op   = &func3_i;                         // code 7
    assign base_mask = (8'h01 << (4'd1 << sz_log)) - 8'h01;   // 1,3,f and wraps to ff

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= S_IDLE;
            ack_o      <= 1'b0;
            err_o      <= 1'b0;
            dc_valid_o <= 1'b0;
            rdata_o    <= '0;
        end else begin
            case (state_q)
                S_IDLE: if (req_i) begin
                    if (misalign || bad_op) begin
                        ack_o   <= 1'b1;                // answer at once, cache untouched
                        err_o   <= 1'b1;
                        state_q <= S_DONE;
                    end else begin
                        dc_valid_o <= 1'b1;             // edge 1 of a hit
                        state_q    <= S_BUSY;
                    end
                end
                S_BUSY: if (dc_ready_i) begin
                    dc_valid_o <= 1'b0;
                    ack_o      <= 1'b1;                 // edge 3 of a hit
                    if (!dc_wen_o) rdata_o <= ld_data_i;
                    state_q    <= S_DONE;
                end
                default: if (!req_i) begin              // four-phase return to zero
                    ack_o   <= 1'b0;
                    err_o   <= 1'b0;
                    rdata_o <= '0;
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // request payload, captured once per access
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req_i) begin
            dc_wen_o      <= wen_i;
            dc_addr_o.raw <= addr_i;
            dc_wmask_o    <= base_mask << off;          // byte lanes of the store
            dc_wdata_o    <= wdata_i << {off, 3'b000};
            size_q        <= func3_i;
        end
    end

    assign ld_word_o = dc_rdata_i;
    assign ld_off_o  = dc_addr_o.raw[`DC_OFF_W-1:0];
    assign ld_size_o = size_q;

    // request held with the same address until the cache answers
    a_valid_hold: assert property (@(posedge clk) disable iff (rst)
        dc_valid_o && !dc_ready_i |=> dc_valid_o && $stable(dc_addr_o));

    // an answer only ever follows a live request
    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack_o) |-> $past(req_i));

endmodule

/* mem_stage_top.sv */
`timescale 1ns/10ps
`include "lsu_defines.svh"

module mem_stage_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_i,
    input  logic                     wen_i,
    input  lsu_pkg::lsu_size_e       func3_i,
    input  logic [`LSU_ADDR_W-1:0]   addr_i,
    input  logic [`LSU_DATA_W-1:0]   wdata_i,
    output logic                     ack_o,
    output logic                     err_o,
    output logic [`LSU_DATA_W-1:0]   rdata_o
);
    import lsu_pkg::*;

    // controller <-> cache
    logic                     dc_valid, dc_wen, dc_ready;
    dcache_addr_u             dc_addr;
    logic [`LSU_BYTES-1:0]    dc_wmask;
    logic [`LSU_DATA_W-1:0]   dc_wdata, dc_rdata;
    // cache <-> ram
    logic                     ram_req, ram_wen, ram_ack;
    logic [`LSU_ADDR_W-1:0]   ram_addr;
    logic [`LSU_BYTES-1:0]    ram_wmask;
    logic [`LSU_DATA_W-1:0]   ram_wdata, ram_rdata;
    // controller <-> aligner
    logic [`LSU_DATA_W-1:0]   ld_word, ld_data;
    logic [`DC_OFF_W-1:0]     ld_off;
    lsu_size_e                ld_size;

    mem_access_ctrl i_mem_access_ctrl (
        .clk, .rst, .req_i, .wen_i, .func3_i, .addr_i, .wdata_i,
        .ack_o, .err_o, .rdata_o,
        .dc_valid_o(dc_valid), .dc_wen_o(dc_wen), .dc_addr_o(dc_addr),
        .dc_wmask_o(dc_wmask), .dc_wdata_o(dc_wdata),
        .dc_ready_i(dc_ready), .dc_rdata_i(dc_rdata),
        .ld_word_o(ld_word), .ld_off_o(ld_off), .ld_size_o(ld_size), .ld_data_i(ld_data)
    );

    dcache i_dcache (
        .clk, .rst,
        .dc_valid_i(dc_valid), .dc_wen_i(dc_wen), .dc_addr_i(dc_addr),
        .dc_wmask_i(dc_wmask), .dc_wdata_i(dc_wdata),
        .dc_ready_o(dc_ready), .dc_rdata_o(dc_rdata),
        .ram_req_o(ram_req), .ram_wen_o(ram_wen), .ram_addr_o(ram_addr),
        .ram_wmask_o(ram_wmask), .ram_wdata_o(ram_wdata),
        .ram_ack_i(ram_ack), .ram_rdata_i(ram_rdata)
    );

    data_ram i_data_ram (
        .clk, .rst,
        .ram_req_i(ram_req), .ram_wen_i(ram_wen), .ram_addr_i(ram_addr),
        .ram_wmask_i(ram_wmask), .ram_wdata_i(ram_wdata),
        .ram_ack_o(ram_ack), .ram_rdata_o(ram_rdata)
    );

    load_align i_load_align (
        .word_i(ld_word), .off_i(ld_off), .size_i(ld_size), .data_o(ld_data)
    );

endmodule

/* tb_mem_stage.sv */
`timescale 1ns/10ps
`include "lsu_defines.svh"

module tb_mem_stage;
    import lsu_pkg::*;

    logic                     clk;
    logic                     rst;
    logic                     req_i;
    logic                     wen_i;
    lsu_size_e                func3_i;
    logic [`LSU_ADDR_W-1:0]   addr_i;
    logic [`LSU_DATA_W-1:0]   wdata_i;
    logic                     ack_o;
    logic                     err_o;
    logic [`LSU_DATA_W-1:0]   rdata_o;

    logic [7:0]               mem_model [512];    // 64 words of bytes
    logic [`LSU_DATA_W-1:0]   exp_rdata;          // zero for stores and errors
    logic                     exp_err;
    logic                     exp_hit;            // set only when a hit is certain
    integer                   seed;

    mem_stage_top i_mem_stage_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    // bytes of the access extended by func3 bit 2
    function automatic logic [63:0] predict(input logic [2:0] f3, input logic [31:0] addr);
        int          n;
        int          i;
        logic [8:0]  bi;
        logic [63:0] v;
        logic [63:0] top;
        n = 1 << f3[1:0];
        v = '0;
        for (i = 0; i < n; i++) begin
            bi = addr[8:0] + 9'(i);
            v  = v | (64'(mem_model[bi]) << (8 * i));
        end
        top = v >> (8 * n - 1);
        if (!f3[2] && n < 8 && top[0]) v = v | (~64'd0 << (8 * n));   // sign fill
        return v;
    endfunction

    // one four-phase access then one idle cycle with req low
    task automatic do_access(input logic wen, input logic [2:0] f3, input logic [31:0] addr,
                             input logic [63:0] wdata, input logic hit);
        int         n;
        int         i;
        logic [8:0] bi;
        n         = 1 << f3[1:0];
        exp_err   = (f3 == 3'd7) || ((addr & 32'(n - 1)) != 32'd0);
        exp_hit   = hit;
        exp_rdata = (!wen && !exp_err) ? predict(f3, addr) : '0;
        wen_i     = wen;
        func3_i   = lsu_size_e'(f3);
        addr_i    = addr;
        wdata_i   = wdata;
        req_i     = 1'b1;
        do begin
            @(posedge clk);
            #2;
        end while (!ack_o);
        req_i = 1'b0;
        do begin
            @(posedge clk);
            #2;
        end while (ack_o);
        if (wen && !exp_err) begin                    // model follows aligned stores only
            for (i = 0; i < n; i++) begin
                bi            = addr[8:0] + 9'(i);
                mem_model[bi] = 8'(wdata >> (8 * i));
            end
        end
        @(posedge clk);                               // req low for a second edge
        #2;
    endtask

    a_rdata: assert property (@(posedge clk) disable iff (rst)
        ack_o && !err_o |-> rdata_o == exp_rdata) else fail_now("rdata differs from model");
    a_err: assert property (@(posedge clk) disable iff (rst)
        ack_o |-> err_o == exp_err) else fail_now("err_o differs from expected");
    a_err_time: assert property (@(posedge clk) disable iff (rst)
        $rose(ack_o) && exp_err |-> $past(req_i) && !$past(req_i, 2))
        else fail_now("error answer not one cycle after request");
    a_hit_time: assert property (@(posedge clk) disable iff (rst)
        $rose(ack_o) && exp_hit |-> $past(req_i, 3) && !$past(req_i, 4))
        else fail_now("load hit not answered in three cycles");
    a_ack_drop: assert property (@(posedge clk) disable iff (rst)
        !req_i && !$past(req_i) |-> !ack_o) else fail_now("ack_o high without request");
    a_reset: assert property (@(posedge clk)
        rst |=> !ack_o && !err_o) else fail_now("ack_o or err_o high in reset");

    initial begin
        #(300 * 30 * 40);                             // 300 accesses of 30 cycles
        $display("Timeout: the run did not finish in time");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] r;
        logic [2:0]  f3;
        logic [2:0]  a_off;
        int          k;
        seed      = 32'he8fa143b;
        rst       = 1'b1;
        req_i     = 1'b0;
        wen_i     = 1'b0;
        func3_i   = LSU_D;
        addr_i    = '0;
        wdata_i   = '0;
        exp_rdata = '0;
        exp_err   = 1'b0;
        exp_hit   = 1'b0;
        for (k = 0; k < 512; k++) mem_model[k] = 8'h00;   // ram starts at zero
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        do_access(1'b1, 3'd3, 32'h28, 64'h8182_8384_f5f6_f7f8, 1'b0);   // negative bytes
        do_access(1'b0, 3'd0, 32'h28, '0, 1'b0);      // lb
        do_access(1'b0, 3'd4, 32'h28, '0, 1'b0);      // lbu
        do_access(1'b0, 3'd1, 32'h2e, '0, 1'b0);      // lh
        do_access(1'b0, 3'd5, 32'h2e, '0, 1'b0);
        do_access(1'b0, 3'd2, 32'h2c, '0, 1'b0);      // lw
        do_access(1'b0, 3'd6, 32'h2c, '0, 1'b0);
        do_access(1'b1, 3'd1, 32'h29, 64'hdead, 1'b0);          // misaligned store
        do_access(1'b1, 3'd2, 32'h2a, 64'hbeef_cafe, 1'b0);
        do_access(1'b0, 3'd3, 32'h2c, '0, 1'b0);
        do_access(1'b0, 3'd7, 32'h28, '0, 1'b0);      // illegal func3
        do_access(1'b1, 3'd7, 32'h28, 64'h1234, 1'b0);
        do_access(1'b0, 3'd3, 32'h28, '0, 1'b0);      // still the old word
        do_access(1'b0, 3'd3, 32'h28, '0, 1'b1);      // repeat that must hit
        do_access(1'b1, 3'd2, 32'h28, 64'h0bad_f00d, 1'b0);     // store hit with write-through
        do_access(1'b0, 3'd3, 32'h28, '0, 1'b1);
        do_access(1'b0, 3'd3, 32'h68, '0, 1'b0);      // same index evicts the line
        do_access(1'b0, 3'd3, 32'h28, '0, 1'b0);      // refill from ram

        for (k = 0; k < 250; k++) begin
            r     = $random(seed);
            f3    = r[2:0];
            a_off = r[5:3];
            if (r[15:13] != 3'd0) a_off = a_off & ~(3'(1 << f3[1:0]) - 3'd1);  // mostly aligned
            do_access(r[16], f3, {23'd0, r[11:6], a_off},
                      {32'($random(seed)), 32'($random(seed))}, 1'b0);
        end

        $display("Test passed");
        $finish;
    end

endmodule
